//--- src/periph_pkg.sv
/*
 * Peripheral port definitions
 * Address map, register select encoding, widths and the audio write word
 */

`default_nettype none

package periph_pkg;

    // CPU bus
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    // Region field sits in address bits 19:16
    localparam int REGION_LSB = 16;
    localparam int REGION_W = 4;

    localparam logic [REGION_W-1:0] REGION_DSP = 4'd1;
    localparam logic [REGION_W-1:0] REGION_AUDIO = 4'd2;

    // Register select is word offset bits 3:2
    localparam int SEL_LSB = 2;

    // DSP multiplier
    localparam int DSP_OPERAND_W = 16;
    localparam int DSP_PRODUCT_W = 32;

    // YM2151 host port and prescaler
    localparam int YM_DATA_W = 8;
    localparam int YM_ACC_W = 33;

    // DSP: bit 0 picks operand B
    // Audio: bit 1 picks the prescaler, bit 0 is YM a0
    typedef logic [1:0] reg_sel_t;

    typedef union packed {
        logic [DATA_W-1:0] prescaler;
        struct packed {
            logic [DATA_W-YM_DATA_W-1:0] unused;
            logic [YM_DATA_W-1:0]        ym_data;
        } ym;
    } audio_wword_t;

endpackage

`default_nettype wire

//--- src/periph_bus_if.sv
/*
 * Internal peripheral bus
 * Carries decoded write strobes, register select and write data
 * from the CPU bus decoder out to the peripherals
 */

`timescale 1ns/100ps
`default_nettype none

interface periph_bus_if import periph_pkg::*; ();

    // One-cycle write strobes, one per region
    logic dsp_write;
    logic audio_write;

    // Registered word offset and data of the accepted access
    reg_sel_t reg_sel;
    logic [DATA_W-1:0] write_data;

    modport ctrl (
        output dsp_write,
        output audio_write,
        output reg_sel,
        output write_data
    );

    modport periph (
        input dsp_write,
        input audio_write,
        input reg_sel,
        input write_data
    );

endinterface

`default_nettype wire

//--- src/cpu_bus_decoder.sv
/*
 * CPU bus decoder
 * Accepts one transaction at a time, decodes the region field,
 * issues one-cycle write strobes and returns read data with ready
 * in the cycle after acceptance
 */

`timescale 1ns/100ps
`default_nettype none

module cpu_bus_decoder import periph_pkg::*; (
    input  wire logic                     cpu_clk,
    input  wire logic                     cpu_reset,

    input  wire logic                     mem_valid,
    input  wire logic [ADDR_W-1:0]        mem_addr,
    input  wire logic [STRB_W-1:0]        mem_wstrb,
    input  wire logic [DATA_W-1:0]        mem_wdata,
    output logic                          mem_ready,
    output logic [DATA_W-1:0]             mem_rdata,

    input  wire logic [DSP_PRODUCT_W-1:0] dsp_product,
    input  wire logic [YM_DATA_W-1:0]     ym_status,

    periph_bus_if.ctrl                    bus
);

    logic [REGION_W-1:0] region;
    reg_sel_t            sel;
    logic                is_write;
    logic                accept;

    logic                dsp_hit_q;
    logic                audio_hit_q;
    logic                write_q;
    reg_sel_t            sel_q;
    logic [DATA_W-1:0]   wdata_q;

    assign region = mem_addr[REGION_LSB +: REGION_W];
    assign sel = mem_addr[SEL_LSB +: $bits(reg_sel_t)];

    // Any byte lane enabled counts as a full word write
    assign is_write = |mem_wstrb;

    // Ready doubles as the outstanding flag, so N+1 never accepts
    assign accept = mem_valid && !mem_ready;

    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            mem_ready <= 1'b0;
            dsp_hit_q <= 1'b0;
            audio_hit_q <= 1'b0;
            write_q <= 1'b0;
        end else begin
            mem_ready <= accept;

            if (accept) begin
                dsp_hit_q <= (region == REGION_DSP);
                audio_hit_q <= (region == REGION_AUDIO);
                write_q <= is_write;
            end
        end
    end

    // Select and data of the accepted access
    always_ff @(posedge cpu_clk) begin
        if (accept) begin
            sel_q <= sel;
            wdata_q <= mem_wdata;
        end
    end

    // Strobes line up with mem_ready
    assign bus.dsp_write = mem_ready && write_q && dsp_hit_q;
    assign bus.audio_write = mem_ready && write_q && audio_hit_q;
    assign bus.reg_sel = sel_q;
    assign bus.write_data = wdata_q;

    // Read data by registered region, unmapped reads as zero
    always_comb begin
        mem_rdata = '0;

        if (dsp_hit_q) begin
            mem_rdata = dsp_product;
        end else if (audio_hit_q) begin
            mem_rdata = {{(DATA_W - YM_DATA_W){1'b0}}, ym_status};
        end
    end

endmodule

`default_nettype wire

//--- src/dsp_multiplier.sv
/*
 * DSP multiplier
 * Two 16-bit operand registers and a registered signed product
 */

`timescale 1ns/100ps
`default_nettype none

module dsp_multiplier import periph_pkg::*; (
    input  wire logic                     cpu_clk,

    periph_bus_if.periph                  bus,

    output logic [DSP_PRODUCT_W-1:0]      product
);

    logic signed [DSP_OPERAND_W-1:0] op_a;
    logic signed [DSP_OPERAND_W-1:0] op_b;

    // Flat enables keep the operands mappable onto DSP input registers
    always_ff @(posedge cpu_clk) begin
        if (bus.dsp_write && !bus.reg_sel[0]) begin
            op_a <= bus.write_data[DSP_OPERAND_W-1:0];
        end

        if (bus.dsp_write && bus.reg_sel[0]) begin
            op_b <= bus.write_data[DSP_OPERAND_W-1:0];
        end
    end

    // Product follows the operands one cycle later
    always_ff @(posedge cpu_clk) begin
        product <= DSP_PRODUCT_W'($signed(op_a) * $signed(op_b));
    end

endmodule

`default_nettype wire

//--- src/ym_ctrl.sv
/*
 * YM2151 control
 * Software prescaler driving the cen and cen_p1 clock enables,
 * plus the latched host port write
 */

`timescale 1ns/100ps
`default_nettype none

module ym_ctrl import periph_pkg::*; (
    input  wire logic                 cpu_clk,
    input  wire logic                 cpu_reset,

    periph_bus_if.periph              bus,

    output logic                      ym_cen,
    output logic                      ym_cen_p1,
    output logic                      ym_wr,
    output logic                      ym_a0,
    output logic [YM_DATA_W-1:0]      ym_din
);

    audio_wword_t          wword;
    logic                  port_write;
    logic                  prescaler_write;

    logic [DATA_W-1:0]     prescaler;
    logic [YM_ACC_W-1:0]   acc;
    logic                  tick;
    logic                  p1_toggle;

    assign wword = bus.write_data;

    // Offset bit 1 splits the region into YM port and prescaler
    assign port_write = bus.audio_write && !bus.reg_sel[1];
    assign prescaler_write = bus.audio_write && bus.reg_sel[1];

    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            prescaler <= '0;
        end else if (prescaler_write) begin
            prescaler <= wword.prescaler;
        end
    end

    // Fractional accumulator
    // Carry out of the low 32 bits lands in the top bit for one cycle
    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            acc <= '0;
            tick <= 1'b0;
        end else begin
            acc <= {1'b0, acc[DATA_W-1:0]} + {1'b0, prescaler};
            tick <= acc[YM_ACC_W-1];
        end
    end

    // Full-rate enable on each tick, half-rate on every second one
    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            ym_cen <= 1'b0;
            ym_cen_p1 <= 1'b0;
            p1_toggle <= 1'b0;
        end else begin
            ym_cen <= tick;
            ym_cen_p1 <= 1'b0;

            if (tick) begin
                ym_cen_p1 <= p1_toggle;
                p1_toggle <= !p1_toggle;
            end
        end
    end

    // Host port data and address, held until the next port write
    always_ff @(posedge cpu_clk) begin
        if (port_write) begin
            ym_din <= wword.ym.ym_data;
            ym_a0 <= bus.reg_sel[0];
        end
    end

    // Write pulse follows the latch, independent of the enables
    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            ym_wr <= 1'b0;
        end else begin
            ym_wr <= port_write;
        end
    end

endmodule

`default_nettype wire

//--- src/periph_top.sv
/*
 * Peripheral port top level
 * CPU bus decoder feeding the DSP multiplier and YM2151 control
 */

`timescale 1ns/100ps
`default_nettype none

module periph_top import periph_pkg::*; (
    input  wire logic                 cpu_clk,
    input  wire logic                 cpu_reset,

    // CPU bus
    input  wire logic                 mem_valid,
    input  wire logic [ADDR_W-1:0]    mem_addr,
    input  wire logic [STRB_W-1:0]    mem_wstrb,
    input  wire logic [DATA_W-1:0]    mem_wdata,
    output logic                      mem_ready,
    output logic [DATA_W-1:0]         mem_rdata,

    // YM2151 host port
    output logic                      ym_cen,
    output logic                      ym_cen_p1,
    output logic                      ym_wr,
    output logic                      ym_a0,
    output logic [YM_DATA_W-1:0]      ym_din,
    input  wire logic [YM_DATA_W-1:0] ym_dout
);

    logic [DSP_PRODUCT_W-1:0] dsp_product;

    periph_bus_if bus ();

    cpu_bus_decoder decoder (
        .cpu_clk(cpu_clk),
        .cpu_reset(cpu_reset),

        .mem_valid(mem_valid),
        .mem_addr(mem_addr),
        .mem_wstrb(mem_wstrb),
        .mem_wdata(mem_wdata),
        .mem_ready(mem_ready),
        .mem_rdata(mem_rdata),

        .dsp_product(dsp_product),
        .ym_status(ym_dout),

        .bus(bus.ctrl)
    );

    dsp_multiplier dsp (
        .cpu_clk(cpu_clk),
        .bus(bus.periph),
        .product(dsp_product)
    );

    ym_ctrl ym (
        .cpu_clk(cpu_clk),
        .cpu_reset(cpu_reset),

        .bus(bus.periph),

        .ym_cen(ym_cen),
        .ym_cen_p1(ym_cen_p1),
        .ym_wr(ym_wr),
        .ym_a0(ym_a0),
        .ym_din(ym_din)
    );

endmodule

`default_nettype wire

//--- dv/periph_tb.sv
/*
 * Peripheral port testbench
 * Drives the CPU bus through reset, ready timing, the DSP multiplier,
 * YM host writes, status reads and the prescaler clock enables
 */

`timescale 1ns/100ps
`default_nettype none

module periph_tb import periph_pkg::*; ();

    localparam int CLK_HALF = 5;
    localparam int RESET_CYCLES = 10;
    localparam int READY_LIMIT = 8;
    localparam int DSP_PAIRS = 6;
    localparam int YM_WRITES = 8;
    localparam int STATUS_READS = 4;
    localparam int PRESCALER_WINDOW = 400;

    // Watchdog budget from the test lengths, about 8 cycles per access
    localparam int ACCESS_CYCLES = 8;
    localparam int ACCESS_COUNT = 4 + 3 * DSP_PAIRS + YM_WRITES + 1 + STATUS_READS + 2;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + ACCESS_COUNT * ACCESS_CYCLES
                                     + 2 * PRESCALER_WINDOW + 200;

    localparam logic [ADDR_W-1:0] DSP_BASE = ADDR_W'(REGION_DSP) << REGION_LSB;
    localparam logic [ADDR_W-1:0] AUDIO_BASE = ADDR_W'(REGION_AUDIO) << REGION_LSB;
    localparam logic [ADDR_W-1:0] UNMAPPED_ADDR = 32'h0003_0004;
    localparam logic [ADDR_W-1:0] OPERAND_A_OFS = 32'h0;
    localparam logic [ADDR_W-1:0] OPERAND_B_OFS = 32'h4;
    localparam logic [ADDR_W-1:0] YM_ADDR_OFS = 32'h0;
    localparam logic [ADDR_W-1:0] YM_DATA_OFS = 32'h4;
    localparam logic [ADDR_W-1:0] PRESCALER_OFS = 32'h8;

    logic                 cpu_clk = 1'b0;
    logic                 cpu_reset;
    logic                 mem_valid;
    logic [ADDR_W-1:0]    mem_addr;
    logic [STRB_W-1:0]    mem_wstrb;
    logic [DATA_W-1:0]    mem_wdata;
    logic                 mem_ready;
    logic [DATA_W-1:0]    mem_rdata;
    logic                 ym_cen;
    logic                 ym_cen_p1;
    logic                 ym_wr;
    logic                 ym_a0;
    logic [YM_DATA_W-1:0] ym_din;
    logic [YM_DATA_W-1:0] ym_dout;

    int    seed;
    int    error_count = 0;
    int    test_count = 0;
    int    failed_tests = 0;
    int    errors_at_test_start;
    string test_name;
    int    wr_pulses = 0;
    logic  prescaler_written = 1'b0;

    // YM host port as seen in the ready cycle and in the cycle after it
    logic                 ready_ym_wr;
    logic                 next_ym_wr;
    logic                 next_ym_a0;
    logic [YM_DATA_W-1:0] next_ym_din;

    periph_top dut_i (
        .cpu_clk(cpu_clk),
        .cpu_reset(cpu_reset),
        .mem_valid(mem_valid),
        .mem_addr(mem_addr),
        .mem_wstrb(mem_wstrb),
        .mem_wdata(mem_wdata),
        .mem_ready(mem_ready),
        .mem_rdata(mem_rdata),
        .ym_cen(ym_cen),
        .ym_cen_p1(ym_cen_p1),
        .ym_wr(ym_wr),
        .ym_a0(ym_a0),
        .ym_din(ym_din),
        .ym_dout(ym_dout)
    );

    always #CLK_HALF cpu_clk = ~cpu_clk;

    // Counts cycles with ym_wr high
    always @(negedge cpu_clk) begin
        if (ym_wr) begin
            wr_pulses = wr_pulses + 1;
        end
    end

    assert property (@(posedge cpu_clk) disable iff (cpu_reset) mem_ready |=> !mem_ready)
        else begin
            error_count++;
            $display("FAILED mem_ready: got 0x1 in the cycle after ready, expected 0x0");
        end

    assert property (@(posedge cpu_clk) disable iff (cpu_reset) ym_cen_p1 |-> ym_cen)
        else begin
            error_count++;
            $display("FAILED ym_cen_p1: got 0x1 while ym_cen is 0x0");
        end

    // No enables before software sets a rate
    assert property (@(posedge cpu_clk) disable iff (cpu_reset)
                     !prescaler_written |-> !ym_cen && !ym_cen_p1)
        else begin
            error_count++;
            $display("FAILED ym_cen: got 0x%0h before any prescaler write, expected 0x0",
                     ym_cen);
        end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            error_count++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_test_start = error_count;
        test_count++;
    endtask

    task automatic end_test();
        int errors;

        errors = error_count - errors_at_test_start;
        if (errors == 0) begin
            $display("test %-12s passed", test_name);
        end else begin
            failed_tests++;
            $display("test %-12s failed with %0d bad checks", test_name, errors);
        end
    endtask

    // One bus transaction, checks ready latency and leaves two idle cycles
    task automatic bus_access(input logic [ADDR_W-1:0] addr, input logic [STRB_W-1:0] wstrb,
                              input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata);
        int wait_cycles;

        @(posedge cpu_clk);
        mem_valid <= 1'b1;
        mem_addr <= addr;
        mem_wstrb <= wstrb;
        mem_wdata <= wdata;

        wait_cycles = 0;
        do begin
            @(negedge cpu_clk);
            wait_cycles++;
        end while (!mem_ready && wait_cycles < READY_LIMIT);

        rdata = mem_rdata;
        ready_ym_wr = ym_wr;
        assert (mem_ready) else begin
            error_count++;
            $display("FAILED: no mem_ready within %0d cycles for address 0x%08h",
                     READY_LIMIT, addr);
        end
        // Accepted in the cycle after the drive edge, ready in the next one
        check_value("mem_ready latency", 32'(wait_cycles), 32'd2);

        @(posedge cpu_clk);
        mem_valid <= 1'b0;
        mem_wstrb <= '0;
        @(negedge cpu_clk);
        check_value("mem_ready after ready cycle", 32'(mem_ready), 32'd0);
        next_ym_wr = ym_wr;
        next_ym_din = ym_din;
        next_ym_a0 = ym_a0;
        @(posedge cpu_clk);
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused_rdata;

        bus_access(addr, '1, data, unused_rdata);
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        bus_access(addr, '0, '0, data);
    endtask

    task automatic reset_test();
        begin_test("reset");
        repeat (RESET_CYCLES) begin
            @(negedge cpu_clk);
            check_value("mem_ready", 32'(mem_ready), 32'd0);
            check_value("ym_cen", 32'(ym_cen), 32'd0);
            check_value("ym_cen_p1", 32'(ym_cen_p1), 32'd0);
            check_value("ym_wr", 32'(ym_wr), 32'd0);
        end
        @(posedge cpu_clk);
        cpu_reset <= 1'b0;
        end_test();
    endtask

    task automatic ready_timing_test();
        logic [DATA_W-1:0] rdata;

        begin_test("ready");
        bus_read(UNMAPPED_ADDR, rdata);
        check_value("mem_rdata (unmapped)", rdata, 32'h0);
        bus_write(UNMAPPED_ADDR, 32'($random(seed)));
        bus_read(DSP_BASE + OPERAND_A_OFS, rdata);
        bus_read(AUDIO_BASE + YM_ADDR_OFS, rdata);
        end_test();
    endtask

    task automatic dsp_product_test();
        logic signed [DSP_OPERAND_W-1:0] op_a;
        logic signed [DSP_OPERAND_W-1:0] op_b;
        logic [DATA_W-1:0]               rdata;
        int                              expected;

        begin_test("dsp");
        for (int i = 0; i < DSP_PAIRS; i++) begin
            if (i == 0) begin
                op_a = -16'sd3;
                op_b = 16'sd1234;
            end else if (i == 1) begin
                op_a = 16'sh8000;
                op_b = -16'sd256;
            end else begin
                op_a = 16'($random(seed));
                op_b = 16'($random(seed));
            end
            // Upper half of the write word carries junk
            bus_write(DSP_BASE + OPERAND_A_OFS, {16'($random(seed)), op_a});
            bus_write(DSP_BASE + OPERAND_B_OFS, {16'($random(seed)), op_b});
            bus_read(DSP_BASE + OPERAND_A_OFS, rdata);
            expected = int'(op_a) * int'(op_b);
            check_value("mem_rdata (product)", rdata, expected);
        end
        end_test();
    endtask

    task automatic ym_write_test();
        logic [YM_DATA_W-1:0] data;
        logic [ADDR_W-1:0]    addr;
        int                   pulses_before;

        begin_test("ym_write");
        for (int i = 0; i < YM_WRITES; i++) begin
            data = 8'($random(seed));
            addr = AUDIO_BASE + (i[0] ? YM_DATA_OFS : YM_ADDR_OFS);
            pulses_before = wr_pulses;
            bus_write(addr, {24'($random(seed)), data});
            @(posedge cpu_clk);
            check_value("ym_wr in ready cycle", 32'(ready_ym_wr), 32'd0);
            check_value("ym_wr", 32'(next_ym_wr), 32'd1);
            check_value("ym_din", 32'(next_ym_din), 32'(data));
            check_value("ym_a0", 32'(next_ym_a0), 32'(addr[2]));
            check_value("ym_wr pulse count", 32'(wr_pulses - pulses_before), 32'd1);
        end

        // A zero prescaler write must not touch the host port
        pulses_before = wr_pulses;
        bus_write(AUDIO_BASE + PRESCALER_OFS, 32'h0);
        @(posedge cpu_clk);
        check_value("ym_wr pulse count", 32'(wr_pulses - pulses_before), 32'd0);
        end_test();
    endtask

    task automatic status_read_test();
        logic [YM_DATA_W-1:0] status;
        logic [DATA_W-1:0]    rdata;

        begin_test("status");
        for (int i = 0; i < STATUS_READS; i++) begin
            status = 8'($random(seed));
            @(posedge cpu_clk);
            ym_dout <= status;
            bus_read(AUDIO_BASE + YM_ADDR_OFS, rdata);
            check_value("mem_rdata (status)", rdata, {24'h0, status});
        end
        end_test();
    endtask

    task automatic prescaler_rate_test(input logic [DATA_W-1:0] rate);
        int cen_count;
        int p1_count;
        int expected;

        begin_test("prescaler");
        prescaler_written = 1'b1;
        bus_write(AUDIO_BASE + PRESCALER_OFS, rate);
        // Rate change passes through acc, tick and cen
        repeat (4) @(posedge cpu_clk);

        cen_count = 0;
        p1_count = 0;
        repeat (PRESCALER_WINDOW) begin
            @(negedge cpu_clk);
            if (ym_cen) begin
                cen_count++;
            end
            if (ym_cen_p1) begin
                p1_count++;
            end
        end

        expected = int'((longint'(PRESCALER_WINDOW) * longint'(rate)) >> 32);
        assert (cen_count >= expected - 1 && cen_count <= expected + 1) else begin
            error_count++;
            $display("FAILED ym_cen count: got 0x%0h, expected 0x%0h within one",
                     cen_count, expected);
        end
        // Half of the cen count, within one
        assert (2 * p1_count >= cen_count - 2 && 2 * p1_count <= cen_count + 2) else begin
            error_count++;
            $display("FAILED ym_cen_p1 count: got 0x%0h, expected 0x%0h/2 within one",
                     p1_count, cen_count);
        end
        end_test();
    endtask

    initial begin
        seed = 32'hcd5e;
        cpu_reset = 1'b1;
        mem_valid = 1'b0;
        mem_addr = '0;
        mem_wstrb = '0;
        mem_wdata = '0;
        ym_dout = '0;

        reset_test();
        dsp_product_test();
        ym_write_test();
        status_read_test();
        // Product and status are nonzero here, so an unmapped read can tell them apart
        ready_timing_test();
        prescaler_rate_test(32'h4000_0000);
        prescaler_rate_test({4'h0, 28'($random(seed))} | 32'h0100_0000);

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge cpu_clk);
        $display("Timeout: tests did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
src/periph_pkg.sv
src/periph_bus_if.sv
src/cpu_bus_decoder.sv
src/dsp_multiplier.sv
src/ym_ctrl.sv
src/periph_top.sv
dv/periph_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the peripheral port testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module periph_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vperiph_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0
